// File: flist.f
design/lsu_pkg.sv
design/store_align.sv
design/load_align.sv
design/agu.sv
design/mem_port.sv
design/data_ram.sv
design/lsu_top.sv
test/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the load/store unit testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module lsu_tb \
    -f flist.f -Mdir obj_dir -o lsu_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/lsu_sim 2>&1 | tee sim.log
grep -q 'Test failures found' sim.log && { echo 'FAIL'; exit 1; }
grep -q 'All tests passed!' sim.log || { echo 'FAIL: run ended without a verdict'; exit 1; }
echo 'PASS'

// File: test/lsu_tb.sv
// Load/store unit testbench with a byte shadow model and concurrent checking assertions
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    localparam int     MEM_WORDS  = 256;
    localparam int     MEM_BYTES  = MEM_WORDS * 4;
    localparam int     MAX_CYCLES = 20000;            // About 400 accesses at 40 cycles plus margin
    localparam vaddr_t WORD_MASK  = vaddr_t'(MEM_BYTES - 4);

    logic    clk;
    logic    resetn;
    logic    req;
    mem_op_t op;
    word_t   src1;
    word_t   src2;
    word_t   wdata;
    logic    ack;
    word_t   rdata;
    logic    exc_load;
    logic    exc_store;

    logic [7:0] shadow [MEM_BYTES];
    word_t      exp_rdata;
    logic       exp_exc_load;
    logic       exp_exc_store;
    logic       check_data;
    string      test_name = "reset";
    int         errors = 0;
    int         txns = 0;
    int         cycles = 0;

    lsu_top #(
        .MEM_WORDS (MEM_WORDS)
    ) lsu_top_i (
        .clk       (clk),
        .resetn    (resetn),
        .req       (req),
        .op        (op),
        .src1      (src1),
        .src2      (src2),
        .wdata     (wdata),
        .ack       (ack),
        .rdata     (rdata),
        .exc_load  (exc_load),
        .exc_store (exc_store)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Load data, checked in the first sampled cycle of ack
    assert property (@(posedge clk) disable iff (!resetn)
        $rose(ack) && check_data |-> rdata == exp_rdata)
        else begin
            errors++;
            $display("error %s: rdata expected %08h actual %08h", test_name, exp_rdata, rdata);
        end

    assert property (@(posedge clk) disable iff (!resetn)
        $rose(ack) |-> exc_load == exp_exc_load && exc_store == exp_exc_store)
        else begin
            errors++;
            $display("error %s: exc_load/exc_store expected %b%b actual %b%b", test_name,
                     exp_exc_load, exp_exc_store, exc_load, exc_store);
        end

    assert property (@(posedge clk) $rose(resetn) |-> !ack)
        else begin
            errors++;
            $display("ack was high when reset ended");
        end

    assert property (@(posedge clk) disable iff (!resetn) $rose(ack) |-> $past(req))
        else begin
            errors++;
            $display("ack rose while req was low in test %s", test_name);
        end

    assert property (@(posedge clk) disable iff (!resetn) ack && req |=> ack)
        else begin
            errors++;
            $display("ack dropped while req was still high in test %s", test_name);
        end

    assert property (@(posedge clk) disable iff (!resetn) $fell(ack) |-> !$past(req))
        else begin
            errors++;
            $display("ack fell before req was released in test %s", test_name);
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            errors++;
            $display("Timeout after %0d cycles, a request was never answered", cycles);
            report_and_finish();
        end
    end

    task automatic report_and_finish();
        $display("Summary: %0d accesses, %0d cycles, %0d errors", txns, cycles, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // Expected response from the byte model; stores update it
    task automatic predict(input mem_op_t t_op, input vaddr_t ea, input word_t t_wdata);
        int unsigned a;
        int          size;
        logic        store;
        logic        misaligned;
        a     = ea % MEM_BYTES;
        store = (t_op == SB) || (t_op == SH) || (t_op == SW);
        case (t_op)
            LB, LBU, SB: size = 1;
            LH, LHU, SH: size = 2;
            default:     size = 4;
        endcase
        misaligned    = (a % size) != 0;
        exp_exc_load  = misaligned && !store;
        exp_exc_store = misaligned && store;
        check_data    = !misaligned && !store;
        exp_rdata     = '0;
        if (!misaligned && store) begin
            for (int i = 0; i < size; i++) begin
                shadow[a + i] = t_wdata[8*i +: 8];      // Lowest byte to lowest address
            end
        end else if (!misaligned) begin
            case (t_op)
                LB:      exp_rdata = {{24{shadow[a][7]}}, shadow[a]};
                LBU:     exp_rdata = {24'b0, shadow[a]};
                LH:      exp_rdata = {{16{shadow[a + 1][7]}}, shadow[a + 1], shadow[a]};
                LHU:     exp_rdata = {16'b0, shadow[a + 1], shadow[a]};
                default: exp_rdata = {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
            endcase
        end
    endtask

    // One four-phase access, entered and left on a falling edge
    task automatic run_access(input mem_op_t t_op, input vaddr_t ea, input word_t t_wdata);
        word_t split;
        split = $urandom();
        predict(t_op, ea, t_wdata);
        repeat ($urandom_range(0, 3)) @(negedge clk);  // Idle gap
        while (ack) @(negedge clk);
        op    = t_op;
        src1  = split;
        src2  = ea - split + ($urandom() << 10);      // Upper bits wrap away in the RAM index
        wdata = t_wdata;
        req   = 1'b1;
        while (!ack) @(negedge clk);
        repeat ($urandom_range(0, 3)) @(negedge clk);  // Hold req a while
        req = 1'b0;
        while (ack) @(negedge clk);
        src1  = $urandom();
        src2  = $urandom();
        wdata = $urandom();
        txns++;
    endtask

    task automatic store_load_words();
        vaddr_t base;
        test_name = "sw_lw";
        repeat (40) begin
            base = $urandom() & WORD_MASK;
            run_access(SW, base, $urandom());
            run_access(LW, base, $urandom());
        end
    endtask

    task automatic merge_lanes();
        vaddr_t base;
        test_name = "lane_merge";
        repeat (30) begin
            base = $urandom() & WORD_MASK;
            run_access(SW, base, $urandom());
            if ($urandom_range(0, 1) == 1) begin
                run_access(SB, base + $urandom_range(0, 3), $urandom());
            end else begin
                run_access(SH, base + 2 * $urandom_range(0, 1), $urandom());
            end
            run_access(LW, base, $urandom());
        end
    endtask

    task automatic extend_loads();
        vaddr_t base;
        test_name = "load_extend";
        for (int w = 0; w < 8; w++) begin
            base = $urandom() & WORD_MASK;
            run_access(SW, base, $urandom());
            for (int off = 0; off < 4; off++) begin
                run_access(LB, base + off, $urandom());
                run_access(LBU, base + off, $urandom());
            end
            for (int off = 0; off < 4; off += 2) begin
                run_access(LH, base + off, $urandom());
                run_access(LHU, base + off, $urandom());
            end
        end
    endtask

    task automatic misaligned_faults();
        vaddr_t  base;
        mem_op_t bad_op;
        int      off;
        test_name = "misaligned";
        repeat (20) begin
            base = $urandom() & WORD_MASK;
            run_access(SW, base, $urandom());
            case ($urandom_range(0, 4))
                0:       bad_op = LH;
                1:       bad_op = LHU;
                2:       bad_op = LW;
                3:       bad_op = SH;
                default: bad_op = SW;
            endcase
            if (bad_op == LW || bad_op == SW) begin
                off = $urandom_range(1, 3);
            end else begin
                off = 2 * $urandom_range(0, 1) + 1;    // Odd halfword offset
            end
            run_access(bad_op, base + off, $urandom());
            run_access(LW, base, $urandom());          // Word must be unchanged
        end
    endtask

    initial begin
        void'($urandom(32'h47a9e4a0));
        resetn        = 1'b0;
        req           = 1'b0;
        op            = LW;
        src1          = '0;
        src2          = '0;
        wdata         = '0;
        exp_rdata     = '0;
        exp_exc_load  = 1'b0;
        exp_exc_store = 1'b0;
        check_data    = 1'b0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            shadow[i] = '0;                            // RAM clears on reset
        end
        repeat (16) @(negedge clk);
        resetn = 1'b1;
        repeat (2) @(negedge clk);
        store_load_words();
        merge_lanes();
        extend_loads();
        misaligned_faults();
        repeat (4) @(negedge clk);
        report_and_finish();
    end

endmodule

`default_nettype wire

// File: design/lsu_top.sv
// Load/store unit top level joining the address unit, sequencer, load aligner and RAM
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             req,
    input  lsu_pkg::mem_op_t op,
    input  lsu_pkg::word_t   src1,
    input  lsu_pkg::word_t   src2,
    input  lsu_pkg::word_t   wdata,
    output logic             ack,
    output lsu_pkg::word_t   rdata,
    output logic             exc_load,
    output logic             exc_store
);
    import lsu_pkg::*;

    vaddr_t  addr;
    mem_op_t op_q;
    word_t   wdata_al;
    strobe_t be;
    logic    agu_exc_load;
    logic    agu_exc_store;
    word_t   rd_al;
    logic    mem_req;
    logic    mem_we;
    strobe_t mem_be;
    vaddr_t  mem_addr;
    word_t   mem_wdata;
    logic    mem_ack;
    word_t   mem_rdata;

    agu agu_i (
        .clk       (clk),
        .resetn    (resetn),
        .op        (op),
        .src1      (src1),
        .src2      (src2),
        .wdata     (wdata),
        .addr      (addr),
        .op_q      (op_q),
        .wdata_al  (wdata_al),
        .be        (be),
        .exc_load  (agu_exc_load),
        .exc_store (agu_exc_store)
    );

    load_align load_align_i (
        .op      (op_q),
        .addr_lo (addr[1:0]),
        .rd_in   (mem_rdata),
        .rd      (rd_al)
    );

    mem_port mem_port_i (
        .clk          (clk),
        .resetn       (resetn),
        .req          (req),
        .ack          (ack),
        .op_q         (op_q),
        .addr         (addr),
        .wdata_al     (wdata_al),
        .be           (be),
        .exc_load_in  (agu_exc_load),
        .exc_store_in (agu_exc_store),
        .rd_al        (rd_al),
        .rdata        (rdata),
        .exc_load     (exc_load),
        .exc_store    (exc_store),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_be       (mem_be),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ack      (mem_ack)
    );

    data_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) data_ram_i (
        .clk       (clk),
        .resetn    (resetn),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_be    (mem_be),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: design/data_ram.sv
// Byte-strobed data RAM answering a four-phase request/acknowledge handshake
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int MEM_WORDS = 256
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             mem_req,
    input  logic             mem_we,
    input  lsu_pkg::strobe_t mem_be,
    input  lsu_pkg::vaddr_t  mem_addr,
    input  lsu_pkg::word_t   mem_wdata,
    output logic             mem_ack,
    output lsu_pkg::word_t   mem_rdata
);
    import lsu_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    word_t          mem [MEM_WORDS];
    logic [AW-1:0]  idx;

    assign idx = mem_addr[AW+1:2];                     // Word address wraps at MEM_WORDS

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_ack <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_req && !mem_ack) begin
            mem_ack <= 1'b1;
            if (mem_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_be[b]) begin
                        mem[idx][8*b +: 8] <= mem_wdata[8*b +: 8];
                    end
                end
            end
            mem_rdata <= mem[idx];
        end else if (!mem_req) begin
            mem_ack <= 1'b0;                           // Release phase
        end
    end

    // A write must touch at least one lane
    assert property (@(posedge clk) disable iff (!resetn)
        mem_req && mem_we |-> mem_be != '0);

endmodule

`default_nettype wire

// File: design/mem_port.sv
// Access sequencer that runs the request and memory four-phase handshakes
`timescale 1ns/1ps
`default_nettype none

module mem_port (
    input  logic             clk,
    input  logic             resetn,
    input  logic             req,
    output logic             ack,
    input  lsu_pkg::mem_op_t op_q,
    input  lsu_pkg::vaddr_t  addr,
    input  lsu_pkg::word_t   wdata_al,
    input  lsu_pkg::strobe_t be,
    input  logic             exc_load_in,
    input  logic             exc_store_in,
    input  lsu_pkg::word_t   rd_al,
    output lsu_pkg::word_t   rdata,
    output logic             exc_load,
    output logic             exc_store,
    output logic             mem_req,
    output logic             mem_we,
    output lsu_pkg::strobe_t mem_be,
    output lsu_pkg::vaddr_t  mem_addr,
    output lsu_pkg::word_t   mem_wdata,
    input  logic             mem_ack
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {IDLE, AWAIT, MREQ, MREL, RESP} state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= IDLE;
            ack       <= 1'b0;
            mem_req   <= 1'b0;
            mem_we    <= 1'b0;
            exc_load  <= 1'b0;
            exc_store <= 1'b0;
        end else begin
            case (state)
                IDLE: if (req) state <= AWAIT;         // Let the address stage settle
                AWAIT: begin
                    exc_load  <= exc_load_in;
                    exc_store <= exc_store_in;
                    if (exc_load_in || exc_store_in) begin
                        ack   <= 1'b1;
                        state <= RESP;
                    end else begin
                        mem_req <= 1'b1;
                        mem_we  <= is_store(op_q);
                        state   <= MREQ;
                    end
                end
                MREQ: if (mem_ack) begin
                    mem_req <= 1'b0;
                    mem_we  <= 1'b0;
                    state   <= MREL;
                end
                MREL: if (!mem_ack) begin
                    ack   <= 1'b1;
                    state <= RESP;
                end
                RESP: if (!req) begin
                    ack   <= 1'b0;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == AWAIT) begin
            mem_addr  <= addr;
            mem_wdata <= wdata_al;
            mem_be    <= be;
        end
        if (state == MREQ && mem_ack) rdata <= rd_al;  // RAM word registered last edge
    end

    // Faulted accesses never reach the RAM
    assert property (@(posedge clk) disable iff (!resetn)
        $rose(mem_req) |-> !$past(exc_load_in || exc_store_in));

    assert property (@(posedge clk) disable iff (!resetn) ack && req |=> ack);

endmodule

`default_nettype wire

// File: design/agu.sv
// Address unit that forms the effective address, checks alignment and registers the access
`timescale 1ns/1ps
`default_nettype none

module agu (
    input  logic             clk,
    input  logic             resetn,
    input  lsu_pkg::mem_op_t op,
    input  lsu_pkg::word_t   src1,
    input  lsu_pkg::word_t   src2,
    input  lsu_pkg::word_t   wdata,
    output lsu_pkg::vaddr_t  addr,
    output lsu_pkg::mem_op_t op_q,
    output lsu_pkg::word_t   wdata_al,
    output lsu_pkg::strobe_t be,
    output logic             exc_load,
    output logic             exc_store
);
    import lsu_pkg::*;

    vaddr_t  addr_d;
    word_t   wd_d;
    strobe_t be_d;
    logic    misaligned;

    assign addr_d = src1 + src2;

    always_comb begin
        case (op_size(op))
            3'd2:    misaligned = addr_d[0];
            3'd4:    misaligned = |addr_d[1:0];
            default: misaligned = 1'b0;                // Bytes are always aligned
        endcase
    end

    store_align store_align_i (
        .op      (op),
        .addr_lo (addr_d[1:0]),
        .wd_in   (wdata),
        .wd      (wd_d),
        .be      (be_d)
    );

    always_ff @(posedge clk) begin
        addr     <= addr_d;
        wdata_al <= wd_d;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            op_q      <= LB;
            be        <= '0;
            exc_load  <= 1'b0;
            exc_store <= 1'b0;
        end else begin
            op_q      <= op;
            be        <= be_d;
            exc_load  <= misaligned && !is_store(op);
            exc_store <= misaligned && is_store(op);
        end
    end

endmodule

`default_nettype wire

// File: design/load_align.sv
// Load aligner that picks a byte or halfword from the memory word and extends it
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  lsu_pkg::mem_op_t op,
    input  logic [1:0]       addr_lo,
    input  lsu_pkg::word_t   rd_in,
    output lsu_pkg::word_t   rd
);
    import lsu_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    always_comb begin
        case (addr_lo)
            2'b00:   byte_sel = rd_in[7:0];
            2'b01:   byte_sel = rd_in[15:8];
            2'b10:   byte_sel = rd_in[23:16];
            default: byte_sel = rd_in[31:24];
        endcase
    end

    assign half_sel = addr_lo[1] ? rd_in[31:16] : rd_in[15:0];

    always_comb begin
        case (op)
            LB: begin
                rd = {{24{byte_sel[7]}}, byte_sel};    // Sign extend
            end
            LBU: begin
                rd = {24'b0, byte_sel};
            end
            LH: begin
                rd = {{16{half_sel[15]}}, half_sel};
            end
            LHU: begin
                rd = {16'b0, half_sel};
            end
            default: begin
                rd = rd_in;                            // LW and stores
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/store_align.sv
// Store aligner that moves store data into its byte lanes and builds the byte strobe
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  lsu_pkg::mem_op_t op,
    input  logic [1:0]       addr_lo,
    input  lsu_pkg::word_t   wd_in,
    output lsu_pkg::word_t   wd,
    output lsu_pkg::strobe_t be
);
    import lsu_pkg::*;

    logic [4:0] lane_shift;

    assign lane_shift = {addr_lo, 3'b000};             // Byte offset in bits

    always_comb begin
        case (op)
            SB: begin
                wd = {24'b0, wd_in[7:0]} << lane_shift;
                be = 4'b0001 << addr_lo;
            end
            SH: begin
                if (addr_lo[1]) begin
                    wd = {wd_in[15:0], 16'b0};
                    be = 4'b1100;
                end else begin
                    wd = {16'b0, wd_in[15:0]};
                    be = 4'b0011;
                end
            end
            SW: begin
                wd = wd_in;
                be = 4'b1111;
            end
            default: begin
                wd = '0;                               // Loads write nothing
                be = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/lsu_pkg.sv
// Load/store unit package with the shared word, address, strobe and operation types
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] vaddr_t;
    typedef logic [3:0]  strobe_t;                     // Bit n enables byte lane n

    typedef enum logic [3:0] {
        LB  = 4'd0,
        LBU = 4'd1,
        LH  = 4'd2,
        LHU = 4'd3,
        LW  = 4'd4,
        SB  = 4'd5,
        SH  = 4'd6,
        SW  = 4'd7
    } mem_op_t;

    function automatic logic is_store(input mem_op_t op);
        logic st;
        case (op)
            SB, SH, SW: st = 1'b1;
            default:    st = 1'b0;
        endcase
        return st;
    endfunction

    // Access width in bytes
    function automatic logic [2:0] op_size(input mem_op_t op);
        logic [2:0] size;
        case (op)
            LB, LBU, SB: size = 3'd1;
            LH, LHU, SH: size = 3'd2;
            default:     size = 3'd4;
        endcase
        return size;
    endfunction

endpackage

`default_nettype wire
